// ==== rec_exec_top.f ====
rec_pkg.sv
rec_indirect_fifo.sv
rec_csr_bank.sv
rec_resp_serializer.sv
rec_exec_ctrl.sv
rec_exec_top.sv
rec_exec_props.sv
tb_rec_exec.sv

// ==== Bender.yml ====
package:
  name: rec_exec

sources:
  - rec_pkg.sv
  - rec_indirect_fifo.sv
  - rec_csr_bank.sv
  - rec_resp_serializer.sv
  - rec_exec_ctrl.sv
  - rec_exec_top.sv
  - target: test
    files:
      - rec_exec_props.sv
      - tb_rec_exec.sv

// ==== tb_rec_exec.sv ====
// Simulation top that runs random commands on rec_exec_top and checks them against a model
`timescale 1ns/1ps

module tb_rec_exec;
  import rec_pkg::*;

  localparam int NumRw = 24;
  localparam int NumFifo = 4;
  localparam int NumErr = 10;
  localparam int TotalCmds = 2 * NumRw + 1 + 3 * NumFifo + 4 + 3 * NumErr;
  localparam int CyclesPerCmd = 200;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 cmd_valid_i;
  rec_cmd_t             cmd_i;
  logic                 cmd_done_o;
  logic                 recovery_mode_i;
  logic                 rx_req_o;
  logic                 rx_ack_i;
  logic [WordWidth-1:0] rx_data_i;
  logic                 res_valid_o;
  logic                 res_ready_i;
  logic [LenWidth-1:0]  res_len_o;
  logic                 res_dvalid_o;
  logic                 res_dready_i;
  logic [7:0]           res_data_o;
  logic                 res_dlast_o;
  logic                 fifo_rd_req_i;
  logic                 fifo_rd_ack_o;
  logic [WordWidth-1:0] fifo_rd_data_o;
  logic                 payload_available_o;
  logic                 image_activated_o;

  // Reference model state
  logic [31:0] ref_dev_reset;
  logic [31:0] ref_rec_ctrl;
  logic [31:0] ref_fifo_ctrl0;
  logic [31:0] ref_fifo_ctrl1;
  logic [7:0]  ref_proto;
  logic [31:0] ref_fifo[$];
  int          ref_wr;
  int          ref_rd;
  logic        ref_payload;
  logic        mode_q;

  // Traffic seen on the DUT ports
  logic [31:0] rx_words[$];
  logic [31:0] rx_force[$];
  logic [31:0] rx_word;
  logic [7:0]  rsp_bytes[$];
  logic        rsp_last[$];
  int          rx_req_cnt;
  int          res_valid_cnt;
  logic [15:0] res_len_seen;

  rec_exec_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failing check");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
    end
  endtask

  function automatic int reg_len(input logic [7:0] code);
    case (code)
      8'd36:   return 8;
      8'd37:   return 3;
      8'd38:   return 3;
      8'd45:   return 6;
      8'd46:   return 20;
      default: return 0;
    endcase
  endfunction

  function automatic int base_word(input logic [7:0] code);
    case (code)
      8'd37:   return 2;
      8'd38:   return 3;
      8'd45:   return 4;
      8'd46:   return 6;
      default: return 0;
    endcase
  endfunction

  function automatic logic code_listed(input logic [7:0] code);
    return (code inside {8'd36, 8'd37, 8'd38, 8'd45, 8'd46, 8'd47});
  endfunction

  function automatic logic cmd_is_bad(input rec_cmd_t c);
    return c.error || !code_listed(c.code) || (c.code > 8'd39 && !mode_q)
        || (c.is_rd && c.code == 8'd47);
  endfunction

  function automatic logic [31:0] model_word(input csr_idx_e k);
    case (k)
      DevStatus0:  return {16'h0000, ref_proto, 8'h00};
      DevReset:    return ref_dev_reset;
      RecCtrl:     return ref_rec_ctrl;
      FifoCtrl0:   return ref_fifo_ctrl0;
      FifoCtrl1:   return ref_fifo_ctrl1;
      FifoStatus0: return {30'd0, ref_fifo.size() == 16, ref_fifo.size() == 0};
      FifoStatus1: return 32'(ref_wr);
      FifoStatus2: return 32'(ref_rd);
      FifoStatus3: return 32'd16;
      default:     return '0;
    endcase
  endfunction

  function automatic rec_cmd_t make_cmd(input logic rd, input logic [7:0] code, input int len,
                                        input logic err);
    rec_cmd_t c;
    c.is_rd = rd;
    c.code  = code;
    c.len   = 16'(len);
    c.error = err;
    return c;
  endfunction

  // Words past the register's last word and pushes into a full FIFO are dropped
  task automatic apply_write(input logic [7:0] code);
    foreach (rx_words[k]) begin
      if (code == 8'd47) begin
        if (ref_fifo.size() < 16) begin
          ref_fifo.push_back(rx_words[k]);
          ref_wr = (ref_wr + 1) % 16;
        end
      end else if (k < (reg_len(code) + 3) / 4) begin
        case (base_word(code) + k)
          2: ref_dev_reset = rx_words[k];
          3: ref_rec_ctrl = rx_words[k];
          4: begin
            ref_fifo_ctrl0 = rx_words[k];
            if (rx_words[k][15:8] == 8'd1) begin
              ref_fifo.delete();
              ref_wr = 0;
              ref_rd = 0;
            end
          end
          5: ref_fifo_ctrl1 = rx_words[k];
          default: ;
        endcase
      end
    end
    if (code == 8'd47) ref_payload = 1'b1;
  endtask

  task automatic set_mode(input logic m);
    @(posedge clk_i);
    recovery_mode_i <= m;
    mode_q = m;
  endtask

  task automatic exec_cmd(input rec_cmd_t c);
    logic        bad;
    int          nwords;
    int          cycles;
    int          req0;
    int          val0;
    logic [31:0] w;
    logic [7:0]  exp_bytes[$];
    bad = cmd_is_bad(c);
    if (!bad && c.is_rd) begin
      for (int i = 0; i < reg_len(c.code); i++) begin
        w = model_word(csr_idx_e'(base_word(c.code) + i / 4));
        exp_bytes.push_back(w[8 * (i % 4) +: 8]);
      end
    end
    rsp_bytes.delete();
    rsp_last.delete();
    rx_words.delete();
    req0 = rx_req_cnt;
    val0 = res_valid_cnt;
    @(posedge clk_i);
    cmd_i <= c;
    cmd_valid_i <= 1'b1;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!cmd_done_o);
    if (bad) begin
      check_val("cmd_done_o latency", cycles, 2);
      check_val("rx_req_o pulses", rx_req_cnt - req0, 0);
      check_val("res_valid_o pulses", res_valid_cnt - val0, 0);
    end else if (c.is_rd) begin
      check_val("res_valid_o pulses", res_valid_cnt - val0, 1);
      check_val("res_len_o", res_len_seen, reg_len(c.code));
      check_val("response byte count", rsp_bytes.size(), exp_bytes.size());
      foreach (exp_bytes[i]) begin
        check_val("res_data_o", rsp_bytes[i], exp_bytes[i]);
        check_val("res_dlast_o", rsp_last[i], i == exp_bytes.size() - 1);
      end
    end else begin
      nwords = (c.len + 3) / 4;
      check_val("rx_req_o pulses", rx_req_cnt - req0, nwords);
      check_val("rx words taken", rx_words.size(), nwords);
      if (nwords == 0) check_val("cmd_done_o latency", cycles, 2);
      apply_write(c.code);
    end
    ref_proto = c.error ? 8'h04 : 8'h00;
    check_val("image_activated_o", image_activated_o, ref_rec_ctrl[23:16] == 8'h0F);
    check_val("payload_available_o", payload_available_o, ref_payload);
  endtask

  // Host read port held high until the FIFO reports empty
  task automatic drain_fifo();
    logic done;
    done = 1'b0;
    @(posedge clk_i);
    fifo_rd_req_i <= 1'b1;
    while (!done) begin
      @(negedge clk_i);
      check_val("payload_available_o", payload_available_o, ref_payload);
      check_val("fifo_rd_ack_o", fifo_rd_ack_o, ref_fifo.size() != 0);
      if (ref_fifo.size() == 0) begin
        done = 1'b1;
      end else begin
        check_val("fifo_rd_data_o", fifo_rd_data_o, ref_fifo.pop_front());
        ref_rd = (ref_rd + 1) % 16;
        ref_payload = 1'b0;
      end
    end
    @(posedge clk_i);
    fifo_rd_req_i <= 1'b0;
  endtask

  // RX queue responder acking 1 to 3 cycles after each request
  initial begin
    forever begin
      @(negedge clk_i);
      if (rx_req_o) begin
        rx_word = $urandom;
        if ($urandom_range(0, 3) == 0) rx_word[23:16] = 8'h0F;
        if ($urandom_range(0, 3) == 0) rx_word[15:8] = 8'h01;
        if (rx_force.size() != 0) rx_word = rx_force.pop_front();
        repeat ($urandom_range(1, 3)) @(posedge clk_i);
        rx_ack_i <= 1'b1;
        rx_data_i <= rx_word;
        rx_words.push_back(rx_word);
        @(posedge clk_i);
        rx_ack_i <= 1'b0;
      end
    end
  end

  // Random back-pressure on both response handshakes
  initial begin
    forever begin
      @(posedge clk_i);
      res_dready_i <= ($urandom_range(0, 3) != 0);
      res_ready_i <= ($urandom_range(0, 1) != 0);
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      if (rx_req_o) rx_req_cnt++;
      if (res_valid_o) begin
        res_valid_cnt++;
        res_len_seen = res_len_o;
      end
      if (res_dvalid_o && res_dready_i) begin
        rsp_bytes.push_back(res_data_o);
        rsp_last.push_back(res_dlast_o);
      end
    end
  end

  // Stop at the first failure of a bound protocol assertion
  initial begin
    forever begin
      @(negedge clk_i);
      if (u_dut.u_props.fail_cnt != 0) abort_run("A bound protocol assertion failed");
    end
  end

  initial begin
    repeat (TotalCmds * CyclesPerCmd) @(posedge clk_i);
    abort_run("Watchdog expired: a command or FIFO read did not complete in time");
  end

  initial begin
    int         kind;
    int         n;
    logic [7:0] code;
    logic       err;
    void'($urandom(32'h260a));
    rst_ni = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i = '0;
    recovery_mode_i = 1'b0;
    rx_ack_i = 1'b0;
    rx_data_i = '0;
    res_ready_i = 1'b0;
    res_dready_i = 1'b0;
    fifo_rd_req_i = 1'b0;
    mode_q = 1'b0;
    ref_dev_reset = '0;
    ref_rec_ctrl = '0;
    ref_fifo_ctrl0 = '0;
    ref_fifo_ctrl1 = '0;
    ref_proto = '0;
    ref_wr = 0;
    ref_rd = 0;
    ref_payload = 1'b0;
    rx_req_cnt = 0;
    res_valid_cnt = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Register write then readback with lengths past the register end
    for (int r = 0; r < NumRw; r++) begin
      code = ($urandom_range(0, 1) != 0) ? CmdDeviceReset : CmdRecoveryCtrl;
      exec_cmd(make_cmd(1'b0, code, $urandom_range(1, 12), 1'b0));
      exec_cmd(make_cmd(1'b1, code, 3, 1'b0));
    end
    exec_cmd(make_cmd(1'b0, CmdRecoveryCtrl, 0, 1'b0));

    set_mode(1'b1);
    for (int r = 0; r < NumFifo; r++) begin
      // First round overfills the FIFO
      n = (r == 0) ? 20 : $urandom_range(1, 20);
      exec_cmd(make_cmd(1'b0, CmdFifoData, n * 4 - $urandom_range(0, 3), 1'b0));
      exec_cmd(make_cmd(1'b1, CmdFifoStatus, 20, 1'b0));
      drain_fifo();
      exec_cmd(make_cmd(1'b1, CmdFifoStatus, 20, 1'b0));
    end

    // FIFO clear through FIFO_CTRL byte 1
    exec_cmd(make_cmd(1'b0, CmdFifoData, 20, 1'b0));
    exec_cmd(make_cmd(1'b1, CmdFifoStatus, 20, 1'b0));
    rx_force.push_back(32'h0000_0100);
    exec_cmd(make_cmd(1'b0, CmdFifoCtrl, 4, 1'b0));
    exec_cmd(make_cmd(1'b1, CmdFifoStatus, 20, 1'b0));
    drain_fifo();

    for (int r = 0; r < NumErr; r++) begin
      kind = r % 3;
      err = 1'b0;
      if (kind == 0) begin
        set_mode($urandom_range(0, 1));
        code = ($urandom_range(0, 1) != 0) ? CmdDeviceReset : CmdFifoCtrl;
        err = 1'b1;
      end else if (kind == 1) begin
        set_mode($urandom_range(0, 1));
        code = 8'($urandom_range(0, 255));
        if (code_listed(code)) code = 8'd41;
      end else begin
        set_mode(1'b0);
        code = CmdFifoCtrl + 8'($urandom_range(0, 2));
      end
      exec_cmd(make_cmd($urandom_range(0, 1), code, $urandom_range(0, 8), err));
      exec_cmd(make_cmd(1'b1, CmdDeviceStatus, 8, 1'b0));
      exec_cmd(make_cmd(1'b1, CmdDeviceStatus, 8, 1'b0));
    end

    repeat (4) @(posedge clk_i);
    if (u_dut.u_props.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "bound protocol checks reported failures");
    end
  end

endmodule

// ==== rec_exec_props.sv ====
// Protocol checks on the executor ports, bound into every rec_exec_top instance
`timescale 1ns/1ps

module rec_exec_props (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       cmd_done_i,
  input logic       rx_req_i,
  input logic       res_dvalid_i,
  input logic       res_dready_i,
  input logic [7:0] res_data_i,
  input logic       res_dlast_i
);

  int unsigned fail_cnt = 0;

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_i |=> !cmd_done_i)
    else begin
      $error("cmd_done_o stayed high for more than one cycle");
      fail_cnt++;
    end

  // Byte, last flag and valid hold until accepted
  stream_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_i && !res_dready_i |=> res_dvalid_i && $stable(res_data_i) && $stable(res_dlast_i))
    else begin
      $error("response byte changed while res_dready_i was low");
      fail_cnt++;
    end

  no_rx_in_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_i |-> !rx_req_i)
    else begin
      $error("rx_req_o asserted during a read stream");
      fail_cnt++;
    end

endmodule

bind rec_exec_top rec_exec_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .cmd_done_i   (cmd_done_o),
  .rx_req_i     (rx_req_o),
  .res_dvalid_i (res_dvalid_o),
  .res_dready_i (res_dready_i),
  .res_data_i   (res_data_o),
  .res_dlast_i  (res_dlast_o)
);

// ==== rec_exec_top.sv ====
// Top of the recovery command executor, wiring the FSM to the register bank, FIFO and serializer
`timescale 1ns/1ps

module rec_exec_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_valid_i,
  input  rec_pkg::rec_cmd_t             cmd_i,
  output logic                          cmd_done_o,
  input  logic                          recovery_mode_i,
  output logic                          rx_req_o,
  input  logic                          rx_ack_i,
  input  logic [rec_pkg::WordWidth-1:0] rx_data_i,
  output logic                          res_valid_o,
  input  logic                          res_ready_i,
  output logic [rec_pkg::LenWidth-1:0]  res_len_o,
  output logic                          res_dvalid_o,
  input  logic                          res_dready_i,
  output logic [7:0]                    res_data_o,
  output logic                          res_dlast_o,
  input  logic                          fifo_rd_req_i,
  output logic                          fifo_rd_ack_o,
  output logic [rec_pkg::WordWidth-1:0] fifo_rd_data_o,
  output logic                          payload_available_o,
  output logic                          image_activated_o
);
  import rec_pkg::*;

  csr_wr_t              csr_wr;
  csr_idx_e             rd_idx;
  logic [WordWidth-1:0] rd_word;
  logic                 fifo_push;
  logic [WordWidth-1:0] fifo_data;
  logic                 fifo_clr;
  fifo_stat_t           fifo_stat;
  logic                 proto_we;
  logic [7:0]           proto_code;
  logic                 payload_set;
  logic                 ser_start;
  logic                 ser_word_adv;
  logic                 ser_done;

  rec_exec_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .cmd_valid_i,
    .cmd_i,
    .recovery_mode_i,
    .rx_ack_i,
    .rx_data_i,
    .res_ready_i,
    .ser_word_adv_i (ser_word_adv),
    .ser_done_i     (ser_done),
    .cmd_done_o,
    .rx_req_o,
    .csr_wr_o       (csr_wr),
    .fifo_push_o    (fifo_push),
    .fifo_data_o    (fifo_data),
    .rd_idx_o       (rd_idx),
    .res_valid_o,
    .res_len_o,
    .ser_start_o    (ser_start),
    .proto_we_o     (proto_we),
    .proto_code_o   (proto_code),
    .payload_set_o  (payload_set)
  );

  rec_csr_bank u_csr (
    .clk_i,
    .rst_ni,
    .csr_wr_i            (csr_wr),
    .rd_idx_i            (rd_idx),
    .proto_we_i          (proto_we),
    .proto_code_i        (proto_code),
    .fifo_stat_i         (fifo_stat),
    .payload_set_i       (payload_set),
    .fifo_rd_ack_i       (fifo_rd_ack_o),
    .rd_word_o           (rd_word),
    .fifo_clr_o          (fifo_clr),
    .payload_available_o,
    .image_activated_o
  );

  rec_indirect_fifo u_fifo (
    .clk_i,
    .rst_ni,
    .push_i      (fifo_push),
    .push_data_i (fifo_data),
    .clr_i       (fifo_clr),
    .rd_req_i    (fifo_rd_req_i),
    .rd_ack_o    (fifo_rd_ack_o),
    .rd_data_o   (fifo_rd_data_o),
    .stat_o      (fifo_stat)
  );

  rec_resp_serializer u_ser (
    .clk_i,
    .rst_ni,
    .start_i      (ser_start),
    .len_i        (res_len_o),
    .word_i       (rd_word),
    .res_dready_i,
    .res_dvalid_o,
    .res_data_o,
    .res_dlast_o,
    .word_adv_o   (ser_word_adv),
    .done_o       (ser_done)
  );

endmodule

// ==== rec_exec_ctrl.sv ====
// Command FSM of the recovery executor; checks commands and sequences writes and reads
`timescale 1ns/1ps

module rec_exec_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          cmd_valid_i,
  input  rec_pkg::rec_cmd_t             cmd_i,
  input  logic                          recovery_mode_i,
  input  logic                          rx_ack_i,
  input  logic [rec_pkg::WordWidth-1:0] rx_data_i,
  input  logic                          res_ready_i,
  input  logic                          ser_word_adv_i,
  input  logic                          ser_done_i,
  output logic                          cmd_done_o,
  output logic                          rx_req_o,
  output rec_pkg::csr_wr_t              csr_wr_o,
  output logic                          fifo_push_o,
  output logic [rec_pkg::WordWidth-1:0] fifo_data_o,
  output rec_pkg::csr_idx_e             rd_idx_o,
  output logic                          res_valid_o,
  output logic [rec_pkg::LenWidth-1:0]  res_len_o,
  output logic                          ser_start_o,
  output logic                          proto_we_o,
  output logic [7:0]                    proto_code_o,
  output logic                          payload_set_o
);
  import rec_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    FifoWrite,
    ReadWait,
    ReadLen,
    ReadData,
    Error,
    Done
  } state_e;

  state_e state_q;
  state_e state_d;

  logic                cmd_legal;
  logic                cmd_bad;
  csr_idx_e            base_idx;
  logic [LenWidth-1:0] reg_len;
  logic [2:0]          reg_words;
  logic [LenWidth-1:0] cmd_words;

  csr_idx_e            idx_q;
  logic [LenWidth-1:0] len_q;
  logic [LenWidth-1:0] wcnt_q;
  logic [2:0]          reg_left_q;
  logic                err_q;
  logic                rx_req_q;

  // Base word and byte length of the addressed register
  always_comb begin
    cmd_legal = 1'b1;
    base_idx  = DevStatus0;
    reg_len   = '0;
    case (cmd_i.code)
      CmdDeviceStatus: begin
        base_idx = DevStatus0;
        reg_len  = LenDevStatus;
      end
      CmdDeviceReset: begin
        base_idx = DevReset;
        reg_len  = LenDevReset;
      end
      CmdRecoveryCtrl: begin
        base_idx = RecCtrl;
        reg_len  = LenRecCtrl;
      end
      CmdFifoCtrl: begin
        base_idx = FifoCtrl0;
        reg_len  = LenFifoCtrl;
      end
      CmdFifoStatus: begin
        base_idx = FifoStatus0;
        reg_len  = LenFifoStatus;
      end
      // FIFO data has no register words, payload goes to the FIFO
      CmdFifoData: reg_len = '0;
      default: cmd_legal = 1'b0;
    endcase
  end

  // FIFO data is write only
  assign cmd_bad = cmd_i.error | ~cmd_legal
                 | ((cmd_i.code > LastBasicCmd) & ~recovery_mode_i)
                 | (cmd_i.is_rd & (cmd_i.code == CmdFifoData));

  // Byte counts rounded up to whole words
  assign cmd_words = LenWidth'(cmd_i.len[LenWidth-1:2]) + LenWidth'(|cmd_i.len[1:0]);
  assign reg_words = reg_len[4:2] + {2'b00, |reg_len[1:0]};

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_bad) state_d = Error;
          else if (cmd_i.is_rd) state_d = ReadWait;
          else if (cmd_i.code == CmdFifoData) state_d = FifoWrite;
          else state_d = CsrWrite;
        end
      end
      CsrWrite, FifoWrite: begin
        if (wcnt_q == '0) state_d = Done;
        else if (rx_ack_i && wcnt_q == LenWidth'(1)) state_d = Done;
      end
      ReadWait: if (res_ready_i) state_d = ReadLen;
      ReadLen:  state_d = ReadData;
      ReadData: if (ser_done_i) state_d = Done;
      Error:    state_d = Done;
      default:  state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      rx_req_q   <= 1'b0;
      idx_q      <= DevStatus0;
      len_q      <= '0;
      wcnt_q     <= '0;
      reg_left_q <= '0;
      err_q      <= 1'b0;
    end else begin
      state_q  <= state_d;
      rx_req_q <= 1'b0;
      case (state_q)
        Idle: begin
          rx_req_q <= cmd_valid_i & ~cmd_bad & ~cmd_i.is_rd & (cmd_i.len != '0);
          if (cmd_valid_i) begin
            idx_q      <= base_idx;
            len_q      <= reg_len;
            wcnt_q     <= cmd_words;
            reg_left_q <= reg_words;
            err_q      <= cmd_i.error;
          end
        end
        CsrWrite, FifoWrite: begin
          // Next word is requested right after each ack
          rx_req_q <= rx_ack_i & (wcnt_q > LenWidth'(1));
          if (rx_ack_i) begin
            wcnt_q <= wcnt_q - LenWidth'(1);
            if (reg_left_q != 3'd0) reg_left_q <= reg_left_q - 3'd1;
            // Stay on the last register word, extra words are discarded
            if (reg_left_q > 3'd1) idx_q <= csr_idx_e'(idx_q + 4'd1);
          end
        end
        ReadData: begin
          if (ser_word_adv_i && idx_q != FifoStatus4) idx_q <= csr_idx_e'(idx_q + 4'd1);
        end
        default: ;
      endcase
    end
  end

  assign cmd_done_o = (state_q == Done);
  assign rx_req_o   = rx_req_q;

  assign csr_wr_o.we   = (state_q == CsrWrite) & rx_ack_i & (reg_left_q != 3'd0);
  assign csr_wr_o.idx  = idx_q;
  assign csr_wr_o.data = rx_data_i;

  assign fifo_push_o = (state_q == FifoWrite) & rx_ack_i;
  assign fifo_data_o = rx_data_i;

  assign rd_idx_o    = idx_q;
  assign res_valid_o = (state_q == ReadLen);
  assign res_len_o   = len_q;
  assign ser_start_o = (state_q == ReadLen);

  // Protocol status is updated once per command
  assign proto_we_o   = (state_q == Done);
  assign proto_code_o = err_q ? ProtoErrCrc : ProtoOk;

  assign payload_set_o = (state_q == Idle) & cmd_valid_i & ~cmd_bad & ~cmd_i.is_rd
                       & (cmd_i.code == CmdFifoData);

endmodule

// ==== rec_resp_serializer.sv ====
// Splits register words into the little-endian response byte stream
`timescale 1ns/1ps

module rec_resp_serializer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic [rec_pkg::LenWidth-1:0]  len_i,
  input  logic [rec_pkg::WordWidth-1:0] word_i,
  input  logic                          res_dready_i,
  output logic                          res_dvalid_o,
  output logic [7:0]                    res_data_o,
  output logic                          res_dlast_o,
  output logic                          word_adv_o,
  output logic                          done_o
);
  import rec_pkg::*;

  logic                active_q;
  logic [LenWidth-1:0] left_q;
  logic [1:0]          lane_q;
  logic                accept;
  logic                last;

  assign accept = active_q & res_dready_i;
  assign last   = (left_q == LenWidth'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      left_q   <= '0;
      lane_q   <= '0;
    end else if (start_i) begin
      active_q <= (len_i != '0);
      left_q   <= len_i;
      lane_q   <= '0;
    end else if (accept) begin
      left_q <= left_q - LenWidth'(1);
      lane_q <= lane_q + 2'd1;
      if (last) active_q <= 1'b0;
    end
  end

  assign res_dvalid_o = active_q;
  assign res_dlast_o  = active_q & last;
  assign res_data_o   = word_i[{lane_q, 3'b000} +: 8];

  // Controller moves to the next word after the top byte
  assign word_adv_o = accept & (lane_q == 2'd3);
  assign done_o     = accept & last;

endmodule

// ==== rec_csr_bank.sv ====
// Recovery register bank with write decode, combinational read mux and status flags
`timescale 1ns/1ps

module rec_csr_bank (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  rec_pkg::csr_wr_t              csr_wr_i,
  input  rec_pkg::csr_idx_e             rd_idx_i,
  input  logic                          proto_we_i,
  input  logic [7:0]                    proto_code_i,
  input  rec_pkg::fifo_stat_t           fifo_stat_i,
  input  logic                          payload_set_i,
  input  logic                          fifo_rd_ack_i,
  output logic [rec_pkg::WordWidth-1:0] rd_word_o,
  output logic                          fifo_clr_o,
  output logic                          payload_available_o,
  output logic                          image_activated_o
);
  import rec_pkg::*;

  logic [WordWidth-1:0] dev_status0_q;
  logic [WordWidth-1:0] dev_reset_q;
  logic [WordWidth-1:0] rec_ctrl_q;
  logic [WordWidth-1:0] fifo_ctrl0_q;
  logic [WordWidth-1:0] fifo_ctrl1_q;
  logic                 payload_available_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_status0_q <= '0;
      dev_reset_q   <= '0;
      rec_ctrl_q    <= '0;
      fifo_ctrl0_q  <= '0;
      fifo_ctrl1_q  <= '0;
    end else begin
      // Only the host-writable words take bus writes
      if (csr_wr_i.we) begin
        case (csr_wr_i.idx)
          DevReset:  dev_reset_q <= csr_wr_i.data;
          RecCtrl:   rec_ctrl_q <= csr_wr_i.data;
          FifoCtrl0: fifo_ctrl0_q <= csr_wr_i.data;
          FifoCtrl1: fifo_ctrl1_q <= csr_wr_i.data;
          default: ;
        endcase
      end
      // Protocol status sits in byte 1 of DEVICE_STATUS
      if (proto_we_i) dev_status0_q[15:8] <= proto_code_i;
    end
  end

  // Set by a FIFO data write, cleared once the host starts reading
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      payload_available_q <= 1'b0;
    end else if (fifo_rd_ack_i) begin
      payload_available_q <= 1'b0;
    end else if (payload_set_i) begin
      payload_available_q <= 1'b1;
    end
  end

  always_comb begin
    case (rd_idx_i)
      DevStatus0:  rd_word_o = dev_status0_q;
      DevReset:    rd_word_o = dev_reset_q;
      RecCtrl:     rd_word_o = rec_ctrl_q;
      FifoCtrl0:   rd_word_o = fifo_ctrl0_q;
      FifoCtrl1:   rd_word_o = fifo_ctrl1_q;
      FifoStatus0: rd_word_o = {{(WordWidth - 2){1'b0}}, fifo_stat_i.full, fifo_stat_i.empty};
      FifoStatus1: rd_word_o = WordWidth'(fifo_stat_i.wr_idx);
      FifoStatus2: rd_word_o = WordWidth'(fifo_stat_i.rd_idx);
      FifoStatus3: rd_word_o = WordWidth'(IndirectFifoDepth);
      // DevStatus1 and max transfer size read as zero
      default:     rd_word_o = '0;
    endcase
  end

  assign fifo_clr_o = csr_wr_i.we & (csr_wr_i.idx == FifoCtrl0)
                    & (csr_wr_i.data[15:8] == FifoClrCode);

  assign payload_available_o = payload_available_q;
  assign image_activated_o   = (rec_ctrl_q[23:16] == ImageActivateCode);

endmodule

// ==== rec_indirect_fifo.sv ====
// Indirect FIFO filled by FIFO data writes and drained from the host read port
`timescale 1ns/1ps

module rec_indirect_fifo (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  logic [rec_pkg::WordWidth-1:0] push_data_i,
  input  logic                          clr_i,
  input  logic                          rd_req_i,
  output logic                          rd_ack_o,
  output logic [rec_pkg::WordWidth-1:0] rd_data_o,
  output rec_pkg::fifo_stat_t           stat_o
);
  import rec_pkg::*;

  logic [WordWidth-1:0] mem_q [IndirectFifoDepth];
  logic [IdxWidth-1:0]  wr_idx_q;
  logic [IdxWidth-1:0]  rd_idx_q;
  logic [IdxWidth:0]    cnt_q;
  logic                 empty;
  logic                 full;
  logic                 push_ok;
  logic                 pop;

  // Index step with wrap at the last entry
  function automatic logic [IdxWidth-1:0] next_idx(logic [IdxWidth-1:0] idx);
    return (idx == IdxWidth'(IndirectFifoDepth - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign empty   = (cnt_q == '0);
  assign full    = (cnt_q == (IdxWidth + 1)'(IndirectFifoDepth));
  assign push_ok = push_i & ~full & ~clr_i;
  assign pop     = rd_req_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      cnt_q    <= '0;
    end else if (clr_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) wr_idx_q <= next_idx(wr_idx_q);
      if (pop) rd_idx_q <= next_idx(rd_idx_q);
      case ({push_ok, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_idx_q] <= push_data_i;
  end

  assign rd_ack_o  = pop;
  assign rd_data_o = mem_q[rd_idx_q];

  assign stat_o.empty  = empty;
  assign stat_o.full   = full;
  assign stat_o.wr_idx = wr_idx_q;
  assign stat_o.rd_idx = rd_idx_q;

endmodule

// ==== rec_pkg.sv ====
// Shared widths, command codes, register word map and structs, imported by every executor module
package rec_pkg;

  localparam int unsigned WordWidth = 32;
  localparam int unsigned LenWidth = 16;
  localparam int unsigned IndirectFifoDepth = 16;
  localparam int unsigned IdxWidth = $clog2(IndirectFifoDepth);

  // Recovery command codes
  localparam logic [7:0] CmdDeviceStatus = 8'd36;
  localparam logic [7:0] CmdDeviceReset = 8'd37;
  localparam logic [7:0] CmdRecoveryCtrl = 8'd38;
  localparam logic [7:0] CmdFifoCtrl = 8'd45;
  localparam logic [7:0] CmdFifoStatus = 8'd46;
  localparam logic [7:0] CmdFifoData = 8'd47;

  // Anything above this code is only reachable in recovery mode
  localparam logic [7:0] LastBasicCmd = 8'd39;

  // Protocol status codes
  localparam logic [7:0] ProtoOk = 8'h00;
  localparam logic [7:0] ProtoErrCrc = 8'h04;

  // Register lengths in bytes
  localparam logic [LenWidth-1:0] LenDevStatus = LenWidth'(8);
  localparam logic [LenWidth-1:0] LenDevReset = LenWidth'(3);
  localparam logic [LenWidth-1:0] LenRecCtrl = LenWidth'(3);
  localparam logic [LenWidth-1:0] LenFifoCtrl = LenWidth'(6);
  localparam logic [LenWidth-1:0] LenFifoStatus = LenWidth'(20);

  localparam logic [7:0] ImageActivateCode = 8'h0F;
  localparam logic [7:0] FifoClrCode = 8'd1;

  // Register words, in map order
  typedef enum logic [3:0] {
    DevStatus0,
    DevStatus1,
    DevReset,
    RecCtrl,
    FifoCtrl0,
    FifoCtrl1,
    FifoStatus0,
    FifoStatus1,
    FifoStatus2,
    FifoStatus3,
    FifoStatus4
  } csr_idx_e;

  // Decoded command from the bus receiver
  typedef struct packed {
    logic                is_rd;
    logic [7:0]          code;
    logic [LenWidth-1:0] len;
    logic                error;
  } rec_cmd_t;

  typedef struct packed {
    logic                 we;
    csr_idx_e             idx;
    logic [WordWidth-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic                empty;
    logic                full;
    logic [IdxWidth-1:0] wr_idx;
    logic [IdxWidth-1:0] rd_idx;
  } fifo_stat_t;

endpackage
